// File: mem_bridge.f
verilog/mem_bridge_pkg.sv
verilog/job_if.sv
verilog/wbuf_if.sv
verilog/job_ctrl.sv
verilog/ar_issuer.sv
verilog/rd_buffer.sv
verilog/wr_buffer.sv
verilog/wr_issuer.sv
verilog/mem_bridge.sv
dv/mem_bridge_asserts.sv
dv/tb_mem_bridge.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mem_bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -Wno-fatal \
    --top-module tb_mem_bridge \
    -f mem_bridge.f \
    -Mdir obj_dir -o sim_mem_bridge

# keep running after an assertion error so the final report is printed
./obj_dir/sim_mem_bridge +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log
then
    exit 1
fi
exit 0

// File: dv/tb_mem_bridge.sv
`timescale 1ns/1ps

module tb_mem_bridge;

    // pop to O_mem_din_valid
    localparam int DRAIN_LAT = 3;

    logic                   I_clk = 1'b0;
    logic                   I_rst;
    logic                   I_ap_start;
    mem_bridge_pkg::addr_t  I_ddr_rdw_addr;
    mem_bridge_pkg::addr_t  I_ddr_wr_addr;
    mem_bridge_pkg::bytes_t I_in_dataw_bytes;
    mem_bridge_pkg::bytes_t I_out_data_bytes;
    logic                   I_arready;
    logic                   I_rvalid;
    mem_bridge_pkg::data_t  I_rdata;
    logic                   I_awready;
    logic                   I_wready;
    mem_bridge_pkg::data_t  I_mem_dout;
    logic                   I_mem_dout_valid;
    mem_bridge_pkg::addr_t  O_araddr;
    logic                   O_arvalid;
    logic                   O_rready;
    mem_bridge_pkg::addr_t  O_awaddr;
    logic                   O_awvalid;
    mem_bridge_pkg::data_t  O_wdata;
    logic                   O_wvalid;
    logic                   O_wlast;
    mem_bridge_pkg::data_t  O_mem_din;
    logic                   O_mem_din_valid;
    logic                   O_ap_done;
    logic                   O_ap_ready;

    // expected job, set when a job starts
    mem_bridge_pkg::addr_t  rd_base;
    mem_bridge_pkg::addr_t  wr_base;
    int                     rd_total;
    int                     wr_total;
    int                     ar_count;
    int                     din_count;
    int                     aw_count;
    int                     w_count;
    int                     mismatch_errs;
    int                     other_errs;
    logic                   hold_wready;
    logic                   stall_window;
    mem_bridge_pkg::addr_t  ar_q [$];

    mem_bridge mem_bridge_inst (.*);

    always #20 I_clk = !I_clk;

    // DDR content seen by the slave, a fixed mix of the byte address
    function automatic mem_bridge_pkg::data_t ref_data(input mem_bridge_pkg::addr_t a);
        logic [31:0] h;
        h = a * 32'h9e37_79b9;
        ref_data = {a ^ 32'hc3a5_5a3c, h, ~a, h ^ {a[15:0], a[31:16]}};
    endfunction

    task automatic report_mismatch(input string sig, input mem_bridge_pkg::data_t got,
                                   input mem_bridge_pkg::data_t exp);
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, sig, got, exp);
        mismatch_errs++;
    endtask

    task automatic finish_run();
        int assert_errs;
        assert_errs = mem_bridge_inst.mem_bridge_asserts_inst.fail_count;
        $display("errors: %0d mismatch, %0d other, %0d protocol",
                 mismatch_errs, other_errs, assert_errs);
        if (mismatch_errs + other_errs + assert_errs == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        other_errs++;
        finish_run();
    endtask

    task automatic next_cycle();
        @(posedge I_clk);
        #1;
    endtask

    task automatic start_job(input mem_bridge_pkg::addr_t rd_word, input int in_bytes,
                             input mem_bridge_pkg::addr_t wr_word, input int out_bytes);
        int n;
        next_cycle();
        rd_base   = rd_word * 16;
        wr_base   = wr_word * 16;
        rd_total  = (in_bytes + 15) / 16;
        wr_total  = (out_bytes + 15) / 16;
        ar_count  = 0;
        din_count = 0;
        aw_count  = 0;
        w_count   = 0;
        I_ddr_rdw_addr   = rd_word;
        I_ddr_wr_addr    = wr_word;
        I_in_dataw_bytes = in_bytes;
        I_out_data_bytes = out_bytes;
        I_ap_start       = 1'b1;
        next_cycle();
        I_ap_start = 1'b0;
        // done from the previous job must clear
        n = 0;
        while ((O_ap_done || O_ap_ready) && n < 20)
        begin
            next_cycle();
            n++;
        end
        if (O_ap_done || O_ap_ready)
            abort_on_timeout("done and ready did not clear after start");
    endtask

    // memory-side beats, optionally with random idle cycles between them
    task automatic push_beats(input int n, input bit gaps);
        int i;
        i = 0;
        while (i < n)
        begin
            next_cycle();
            if (gaps && ($urandom % 3 == 0))
                I_mem_dout_valid = 1'b0;
            else
            begin
                I_mem_dout_valid = 1'b1;
                I_mem_dout       = ref_data(wr_base + 16 * i);
                i++;
            end
        end
        next_cycle();
        I_mem_dout_valid = 1'b0;
    endtask

    task automatic wait_read_data(input int limit);
        int n;
        n = 0;
        while (din_count < rd_total && n < limit)
        begin
            next_cycle();
            n++;
        end
        if (din_count < rd_total)
            abort_on_timeout("read data stopped before the last beat");
    endtask

    task automatic wait_watermark(input int limit);
        int n;
        n = 0;
        while (ar_count - din_count < mem_bridge_pkg::RD_WL_THRE && n < limit)
        begin
            next_cycle();
            n++;
        end
        if (ar_count - din_count < mem_bridge_pkg::RD_WL_THRE)
            abort_on_timeout("outstanding reads never reached the watermark");
    endtask

    task automatic wait_job_done(input int limit);
        int n;
        n = 0;
        while (!O_ap_done && n < limit)
        begin
            next_cycle();
            n++;
        end
        if (!O_ap_done)
            abort_on_timeout("ap_done never rose");
        else
        begin
            assert (O_ap_ready) else
            begin
                $display("ap_ready low at %0t while ap_done is high", $time);
                other_errs++;
            end
            assert (w_count == wr_total)
            else report_mismatch("W beat count", w_count, wr_total);
            assert (aw_count == wr_total)
            else report_mismatch("AW count", aw_count, wr_total);
            assert (ar_count == rd_total)
            else report_mismatch("AR count", ar_count, rd_total);
        end
    endtask

    // AXI slave: random ready, R beats returned in order after random gaps
    initial
    begin
        int   r_gap;
        logic r_taken;
        logic wready_held;
        I_arready   = 1'b0;
        I_rvalid    = 1'b0;
        I_rdata     = '0;
        I_awready   = 1'b0;
        I_wready    = 1'b0;
        r_gap       = 0;
        forever
        begin
            @(negedge I_clk);
            if (O_arvalid && I_arready)
                ar_q.push_back(O_araddr);
            r_taken     = I_rvalid && O_rready;
            wready_held = hold_wready;
            next_cycle();
            I_arready = ($urandom % 4) != 0;
            I_awready = ($urandom % 4) != 0;
            I_wready  = !wready_held && (($urandom % 4) != 0);
            if (r_taken)
                I_rvalid = 1'b0;
            if (!I_rvalid)
            begin
                if (r_gap > 0)
                    r_gap--;
                else if (ar_q.size() > 0)
                begin
                    I_rvalid = 1'b1;
                    I_rdata  = ref_data(ar_q.pop_front());
                    r_gap    = $urandom % 4;
                end
            end
        end
    end

    // compare every transfer against the expected sequence
    always @(negedge I_clk)
    begin
        if (!I_rst)
        begin
            if (O_arvalid && I_arready)
            begin
                assert (ar_count < rd_total) else
                begin
                    $display("Read request at %0t beyond the %0d beats of the job",
                             $time, rd_total);
                    other_errs++;
                end
                assert (O_araddr == rd_base + 16 * ar_count)
                else report_mismatch("O_araddr", O_araddr, rd_base + 16 * ar_count);
                ar_count++;
                // drain pipeline beats are counted late, none are in it during a stall
                assert (ar_count - din_count <= mem_bridge_pkg::RD_WL_THRE
                        + (stall_window ? 0 : DRAIN_LAT)) else
                begin
                    $display("Outstanding reads at %0t exceed the watermark: %0d",
                             $time, ar_count - din_count);
                    other_errs++;
                end
            end
            if (O_mem_din_valid)
            begin
                assert (!stall_window) else
                begin
                    $display("Read data emitted at %0t while the write buffer is full", $time);
                    other_errs++;
                end
                assert (O_mem_din == ref_data(rd_base + 16 * din_count))
                else report_mismatch("O_mem_din", O_mem_din, ref_data(rd_base + 16 * din_count));
                din_count++;
            end
            if (O_awvalid && I_awready)
            begin
                assert (O_awaddr == wr_base + 16 * aw_count)
                else report_mismatch("O_awaddr", O_awaddr, wr_base + 16 * aw_count);
                aw_count++;
            end
            if (O_wvalid && I_wready)
            begin
                assert (O_wdata == ref_data(wr_base + 16 * w_count))
                else report_mismatch("O_wdata", O_wdata, ref_data(wr_base + 16 * w_count));
                assert (O_wlast) else report_mismatch("O_wlast", O_wlast, 1);
                w_count++;
            end
        end
    end

    initial
    begin
        int seed;
        seed             = $urandom(32'h600d);
        I_rst            = 1'b1;
        I_ap_start       = 1'b0;
        I_ddr_rdw_addr   = '0;
        I_ddr_wr_addr    = '0;
        I_in_dataw_bytes = '0;
        I_out_data_bytes = '0;
        I_mem_dout       = '0;
        I_mem_dout_valid = 1'b0;
        hold_wready      = 1'b0;
        stall_window     = 1'b0;
        rd_base          = '0;
        wr_base          = '0;
        rd_total         = 0;
        wr_total         = 0;
        ar_count         = 0;
        din_count        = 0;
        aw_count         = 0;
        w_count          = 0;
        mismatch_errs    = 0;
        other_errs       = 0;
        repeat (16) @(posedge I_clk);
        #1;
        I_rst = 1'b0;
        next_cycle();
        assert (!O_ap_done && !O_ap_ready) else
        begin
            $display("ap_done or ap_ready high after reset");
            other_errs++;
        end
        assert (!O_rready && !O_arvalid && !O_awvalid && !O_wvalid && !O_mem_din_valid) else
        begin
            $display("rready or a valid output high after reset");
            other_errs++;
        end

        // 327 read bytes round up to 21 beats, writes arrive with gaps
        start_job(32'h40, 327, 32'h80, 192);
        push_beats(12, 1'b1);
        wait_read_data(4000);
        wait_job_done(4000);

        // W held off, the write buffer passes its threshold and stalls the drain
        hold_wready = 1'b1;
        start_job(32'h1000, 400 * 16, 32'h4000, 220 * 16);
        push_beats(220, 1'b0);
        repeat (DRAIN_LAT + 2) next_cycle();
        stall_window = 1'b1;
        wait_watermark(4000);
        repeat (20) next_cycle();
        stall_window = 1'b0;
        hold_wready  = 1'b0;
        wait_read_data(8000);
        wait_job_done(8000);

        finish_run();
    end

endmodule

// File: dv/mem_bridge_asserts.sv
`timescale 1ns/1ps

module mem_bridge_asserts
(
    input logic                  I_clk,
    input logic                  I_rst,
    input logic                  arvalid,
    input logic                  arready,
    input mem_bridge_pkg::addr_t araddr,
    input logic                  awvalid,
    input logic                  awready,
    input mem_bridge_pkg::addr_t awaddr,
    input logic                  wvalid,
    input logic                  wready,
    input logic                  wlast,
    input logic                  ap_done
);

    int   fail_count = 0;
    logic aw_open;

    // high from an AW transfer until its W transfer
    always_ff @(posedge I_clk)
    begin
        if (I_rst)
            aw_open <= 1'b0;
        else if (awvalid && awready)
            aw_open <= 1'b1;
        else if (wvalid && wready)
            aw_open <= 1'b0;
    end

    ar_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else
    begin
        $error("arvalid dropped or araddr moved before arready");
        fail_count++;
    end

    aw_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
    else
    begin
        $error("awvalid dropped or awaddr moved before awready");
        fail_count++;
    end

    // single-beat bursts
    last_is_valid: assert property (@(posedge I_clk) disable iff (I_rst)
        wlast == wvalid)
    else
    begin
        $error("wlast differs from wvalid");
        fail_count++;
    end

    w_after_aw: assert property (@(posedge I_clk) disable iff (I_rst)
        wvalid |-> aw_open)
    else
    begin
        $error("wvalid raised without a preceding AW transfer");
        fail_count++;
    end

    done_quiet: assert property (@(posedge I_clk) disable iff (I_rst)
        wvalid |-> !ap_done)
    else
    begin
        $error("ap_done high while a write beat is pending");
        fail_count++;
    end

endmodule

bind mem_bridge mem_bridge_asserts mem_bridge_asserts_inst
(
    .I_clk   (I_clk),
    .I_rst   (I_rst),
    .arvalid (O_arvalid),
    .arready (I_arready),
    .araddr  (O_araddr),
    .awvalid (O_awvalid),
    .awready (I_awready),
    .awaddr  (O_awaddr),
    .wvalid  (O_wvalid),
    .wready  (I_wready),
    .wlast   (O_wlast),
    .ap_done (O_ap_done)
);

// File: verilog/mem_bridge.sv
`timescale 1ns/1ps

module mem_bridge
(
    input  logic                   I_clk,
    input  logic                   I_rst,
    input  logic                   I_ap_start,
    input  mem_bridge_pkg::addr_t  I_ddr_rdw_addr,
    input  mem_bridge_pkg::addr_t  I_ddr_wr_addr,
    input  mem_bridge_pkg::bytes_t I_in_dataw_bytes,
    input  mem_bridge_pkg::bytes_t I_out_data_bytes,
    input  logic                   I_arready,
    input  logic                   I_rvalid,
    input  mem_bridge_pkg::data_t  I_rdata,
    input  logic                   I_awready,
    input  logic                   I_wready,
    input  mem_bridge_pkg::data_t  I_mem_dout,
    input  logic                   I_mem_dout_valid,
    output mem_bridge_pkg::addr_t  O_araddr,
    output logic                   O_arvalid,
    output logic                   O_rready,
    output mem_bridge_pkg::addr_t  O_awaddr,
    output logic                   O_awvalid,
    output mem_bridge_pkg::data_t  O_wdata,
    output logic                   O_wvalid,
    output logic                   O_wlast,
    output mem_bridge_pkg::data_t  O_mem_din,
    output logic                   O_mem_din_valid,
    output logic                   O_ap_done,
    output logic                   O_ap_ready
);

    logic rd_drain;
    logic wr_of;
    logic wr_last_done;

    job_if  job ();
    wbuf_if wb ();

    job_ctrl job_ctrl_inst
    (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .ap_start     (I_ap_start),
        .rdw_addr     (I_ddr_rdw_addr),
        .wr_addr      (I_ddr_wr_addr),
        .in_bytes     (I_in_dataw_bytes),
        .out_bytes    (I_out_data_bytes),
        .wr_last_done (wr_last_done),
        .job          (job.ctrl),
        .ap_done      (O_ap_done),
        .ap_ready     (O_ap_ready)
    );

    ar_issuer ar_issuer_inst
    (
        .I_clk    (I_clk),
        .I_rst    (I_rst),
        .job      (job.engine),
        .rd_drain (rd_drain),
        .arready  (I_arready),
        .araddr   (O_araddr),
        .arvalid  (O_arvalid)
    );

    // read data path, paused by the write buffer level
    rd_buffer rd_buffer_inst
    (
        .I_clk         (I_clk),
        .I_rst         (I_rst),
        .job           (job.engine),
        .rvalid        (I_rvalid),
        .rdata         (I_rdata),
        .wr_of         (wr_of),
        .rready        (O_rready),
        .rd_drain      (rd_drain),
        .mem_din       (O_mem_din),
        .mem_din_valid (O_mem_din_valid)
    );

    wr_buffer wr_buffer_inst
    (
        .I_clk          (I_clk),
        .I_rst          (I_rst),
        .mem_dout       (I_mem_dout),
        .mem_dout_valid (I_mem_dout_valid),
        .wb             (wb.buffer),
        .wr_of          (wr_of)
    );

    wr_issuer wr_issuer_inst
    (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .job          (job.engine),
        .wb           (wb.eng),
        .awready      (I_awready),
        .wready       (I_wready),
        .awaddr       (O_awaddr),
        .awvalid      (O_awvalid),
        .wdata        (O_wdata),
        .wvalid       (O_wvalid),
        .wlast        (O_wlast),
        .wr_last_done (wr_last_done)
    );

endmodule

// File: verilog/wr_issuer.sv
`timescale 1ns/1ps

module wr_issuer
(
    input  logic                  I_clk,
    input  logic                  I_rst,
    job_if.engine                 job,
    wbuf_if.eng                   wb,
    input  logic                  awready,
    input  logic                  wready,
    output mem_bridge_pkg::addr_t awaddr,
    output logic                  awvalid,
    output mem_bridge_pkg::data_t wdata,
    output logic                  wvalid,
    output logic                  wlast,
    output logic                  wr_last_done
);

    mem_bridge_pkg::wr_state_t state;
    mem_bridge_pkg::beat_cnt_t beats_done;

    // the head beat leaves the buffer when its address is accepted
    assign wb.pop = (state == mem_bridge_pkg::WR_ADDR) && awready;

    always_ff @(posedge I_clk)
    begin
        if (I_rst)
        begin
            state        <= mem_bridge_pkg::WR_IDLE;
            awvalid      <= 1'b0;
            wvalid       <= 1'b0;
            wlast        <= 1'b0;
            wr_last_done <= 1'b0;
            beats_done   <= '0;
        end
        else
        begin
            wr_last_done <= 1'b0;
            case (state)
                mem_bridge_pkg::WR_IDLE:
                begin
                    if (wb.avail)
                    begin
                        awvalid <= 1'b1;
                        state   <= mem_bridge_pkg::WR_ADDR;
                    end
                end
                mem_bridge_pkg::WR_ADDR:
                begin
                    if (awready)
                    begin
                        awvalid <= 1'b0;
                        // single-beat burst, so every W is the last one
                        wvalid  <= 1'b1;
                        wlast   <= 1'b1;
                        state   <= mem_bridge_pkg::WR_DATA;
                    end
                end
                mem_bridge_pkg::WR_DATA:
                begin
                    if (wready)
                    begin
                        wvalid       <= 1'b0;
                        wlast        <= 1'b0;
                        beats_done   <= beats_done + 1'b1;
                        wr_last_done <= (beats_done + 1'b1 == job.wr_beats);
                        state        <= mem_bridge_pkg::WR_IDLE;
                    end
                end
                default:
                    state <= mem_bridge_pkg::WR_IDLE;
            endcase
            if (job.start)
                beats_done <= '0;
        end
    end

    always_ff @(posedge I_clk)
    begin
        if (job.start)
            awaddr <= job.wr_base;
        else if (awvalid && awready)
            awaddr <= awaddr + mem_bridge_pkg::addr_t'(mem_bridge_pkg::BEAT_BYTES);
        if (wb.pop)
            wdata <= wb.data;
    end

endmodule

// File: verilog/wr_buffer.sv
`timescale 1ns/1ps

module wr_buffer
(
    input  logic                  I_clk,
    input  logic                  I_rst,
    input  mem_bridge_pkg::data_t mem_dout,
    input  logic                  mem_dout_valid,
    wbuf_if.buffer                wb,
    output logic                  wr_of
);

    mem_bridge_pkg::data_t    ram [mem_bridge_pkg::BUF_DEPTH];
    mem_bridge_pkg::data_t    in_data_q;
    logic                     in_vld_q;
    logic                     run_start;
    mem_bridge_pkg::buf_ptr_t wptr;
    mem_bridge_pkg::buf_ptr_t rptr;
    mem_bridge_pkg::level_t   level;

    // first beat of a valid run after a gap
    assign run_start = mem_dout_valid && !in_vld_q;

    assign wb.data  = ram[rptr];
    assign wb.avail = (level != '0);

    always_ff @(posedge I_clk)
    begin
        if (I_rst)
        begin
            in_vld_q <= 1'b0;
            wptr     <= '0;
            rptr     <= '0;
            level    <= '0;
            wr_of    <= 1'b0;
        end
        else
        begin
            in_vld_q <= mem_dout_valid;
            // pointers restart only once the previous run is fully sent
            if (run_start && level == '0)
            begin
                wptr <= '0;
                rptr <= '0;
            end
            else
            begin
                if (in_vld_q)
                    wptr <= wptr + 1'b1;
                if (wb.pop)
                    rptr <= rptr + 1'b1;
            end
            if (in_vld_q && !wb.pop)
                level <= level + 1'b1;
            else if (!in_vld_q && wb.pop)
                level <= level - 1'b1;
            wr_of <= (level > mem_bridge_pkg::WR_WL_THRE);
        end
    end

    always_ff @(posedge I_clk)
    begin
        in_data_q <= mem_dout;
        if (in_vld_q)
            ram[wptr] <= in_data_q;
    end

endmodule

// File: verilog/rd_buffer.sv
`timescale 1ns/1ps

module rd_buffer
(
    input  logic                  I_clk,
    input  logic                  I_rst,
    job_if.engine                 job,
    input  logic                  rvalid,
    input  mem_bridge_pkg::data_t rdata,
    input  logic                  wr_of,
    output logic                  rready,
    output logic                  rd_drain,
    output mem_bridge_pkg::data_t mem_din,
    output logic                  mem_din_valid
);

    mem_bridge_pkg::data_t    ram [mem_bridge_pkg::BUF_DEPTH];
    mem_bridge_pkg::data_t    rx_data;
    mem_bridge_pkg::data_t    ram_q;
    mem_bridge_pkg::data_t    pipe_q;
    logic                     rx_we;
    mem_bridge_pkg::buf_ptr_t wptr;
    mem_bridge_pkg::buf_ptr_t rptr;
    mem_bridge_pkg::level_t   level;
    logic                     pop;
    logic [1:0]               vld_pipe;

    // drain pauses while the write side is backed up
    assign pop      = (level != '0) && !wr_of && !job.start;
    assign rd_drain = pop;

    always_ff @(posedge I_clk)
    begin
        if (I_rst)
        begin
            rready        <= 1'b0;
            rx_we         <= 1'b0;
            wptr          <= '0;
            rptr          <= '0;
            level         <= '0;
            vld_pipe      <= '0;
            mem_din_valid <= 1'b0;
        end
        else
        begin
            if (job.start)
                rready <= 1'b1;
            rx_we <= rvalid && rready;
            if (job.start)
            begin
                wptr  <= '0;
                rptr  <= '0;
                level <= '0;
            end
            else
            begin
                if (rx_we)
                    wptr <= wptr + 1'b1;
                if (pop)
                    rptr <= rptr + 1'b1;
                if (rx_we && !pop)
                    level <= level + 1'b1;
                else if (!rx_we && pop)
                    level <= level - 1'b1;
            end
            // ram read, pipe, output: three cycles after pop
            vld_pipe      <= {vld_pipe[0], pop};
            mem_din_valid <= vld_pipe[1];
        end
    end

    always_ff @(posedge I_clk)
    begin
        rx_data <= rdata;
        if (rx_we)
            ram[wptr] <= rx_data;
        ram_q   <= ram[rptr];
        pipe_q  <= ram_q;
        mem_din <= pipe_q;
    end

endmodule

// File: verilog/ar_issuer.sv
`timescale 1ns/1ps

module ar_issuer
(
    input  logic                  I_clk,
    input  logic                  I_rst,
    job_if.engine                 job,
    input  logic                  rd_drain,
    input  logic                  arready,
    output mem_bridge_pkg::addr_t araddr,
    output logic                  arvalid
);

    mem_bridge_pkg::beat_cnt_t issued;
    mem_bridge_pkg::beat_cnt_t issued_nxt;
    mem_bridge_pkg::beat_cnt_t drained;
    mem_bridge_pkg::beat_cnt_t in_flight;
    logic                      ar_fire;
    logic                      can_issue;

    assign ar_fire    = arvalid && arready;
    assign issued_nxt = ar_fire ? issued + 1'b1 : issued;

    // beats requested but not yet handed to the memory side
    assign in_flight = issued_nxt - drained;

    assign can_issue = (issued_nxt < job.rd_beats)
                    && (in_flight < mem_bridge_pkg::RD_WL_THRE);

    always_ff @(posedge I_clk)
    begin
        if (I_rst)
        begin
            arvalid <= 1'b0;
            issued  <= '0;
            drained <= '0;
        end
        else if (job.start)
        begin
            arvalid <= 1'b0;
            issued  <= '0;
            drained <= '0;
        end
        else
        begin
            issued <= issued_nxt;
            if (rd_drain)
                drained <= drained + 1'b1;
            // a pending request holds until accepted
            arvalid <= (arvalid && !arready) || can_issue;
        end
    end

    // single-beat bursts, address steps one beat
    always_ff @(posedge I_clk)
    begin
        if (job.start)
            araddr <= job.rd_base;
        else if (ar_fire)
            araddr <= araddr + mem_bridge_pkg::addr_t'(mem_bridge_pkg::BEAT_BYTES);
    end

endmodule

// File: verilog/job_ctrl.sv
`timescale 1ns/1ps

module job_ctrl
(
    input  logic                   I_clk,
    input  logic                   I_rst,
    input  logic                   ap_start,
    input  mem_bridge_pkg::addr_t  rdw_addr,
    input  mem_bridge_pkg::addr_t  wr_addr,
    input  mem_bridge_pkg::bytes_t in_bytes,
    input  mem_bridge_pkg::bytes_t out_bytes,
    input  logic                   wr_last_done,
    job_if.ctrl                    job,
    output logic                   ap_done,
    output logic                   ap_ready
);

    logic start_q;
    logic start_edge;
    logic done_flag;

    // byte count rounded up to whole beats
    function automatic mem_bridge_pkg::beat_cnt_t to_beats(input mem_bridge_pkg::bytes_t n);
        to_beats = (n >> mem_bridge_pkg::BEAT_SHIFT)
                 + |n[mem_bridge_pkg::BEAT_SHIFT-1:0];
    endfunction

    assign start_edge = ap_start && !start_q;

    always_ff @(posedge I_clk)
    begin
        if (I_rst)
        begin
            start_q      <= 1'b0;
            job.start    <= 1'b0;
            job.rd_base  <= '0;
            job.wr_base  <= '0;
            job.rd_beats <= '0;
            job.wr_beats <= '0;
            done_flag    <= 1'b0;
        end
        else
        begin
            start_q   <= ap_start;
            job.start <= start_edge;
            if (start_edge)
            begin
                // addresses come in beat units
                job.rd_base  <= rdw_addr << mem_bridge_pkg::BEAT_SHIFT;
                job.wr_base  <= wr_addr << mem_bridge_pkg::BEAT_SHIFT;
                job.rd_beats <= to_beats(in_bytes);
                job.wr_beats <= to_beats(out_bytes);
            end
            if (wr_last_done)
                done_flag <= 1'b1;
            else if (job.start)
                done_flag <= 1'b0;
        end
    end

    assign ap_done  = done_flag;
    assign ap_ready = done_flag;

endmodule

// File: verilog/wbuf_if.sv
`timescale 1ns/1ps

interface wbuf_if;

    mem_bridge_pkg::data_t data;
    logic                  avail;
    logic                  pop;

    // data is the head entry, valid while avail is high
    modport buffer
    (
        output data, avail,
        input  pop
    );

    // pop only while avail, one cycle per beat
    modport eng
    (
        input  data, avail,
        output pop
    );

endinterface

// File: verilog/job_if.sv
`timescale 1ns/1ps

interface job_if;

    logic                      start;
    mem_bridge_pkg::addr_t     rd_base;
    mem_bridge_pkg::addr_t     wr_base;
    mem_bridge_pkg::beat_cnt_t rd_beats;
    mem_bridge_pkg::beat_cnt_t wr_beats;

    // job values are stable from one start pulse to the next
    modport ctrl
    (
        output start, rd_base, wr_base, rd_beats, wr_beats
    );

    modport engine
    (
        input start, rd_base, wr_base, rd_beats, wr_beats
    );

endinterface

// File: verilog/mem_bridge_pkg.sv
package mem_bridge_pkg;

    localparam int DATA_W = 128;
    localparam int ADDR_W = 32;

    // AXI size code for a full 16-byte beat
    localparam int AXI_SIZE_CODE = 4;
    localparam int BEAT_SHIFT = AXI_SIZE_CODE;
    localparam int BEAT_BYTES = 1 << BEAT_SHIFT;

    // entries in each buffer RAM
    localparam int BUF_DEPTH = 256;

    // read beats in flight, issued but not yet drained
    localparam int RD_WL_THRE = 200;

    // write buffer level that pauses the read drain
    localparam int WR_WL_THRE = 200;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [31:0] bytes_t;
    typedef logic [31:0] beat_cnt_t;
    typedef logic [$clog2(BUF_DEPTH)-1:0] buf_ptr_t;

    // one bit wider than the pointer so a full RAM is representable
    typedef logic [$clog2(BUF_DEPTH):0] level_t;

    typedef enum logic [1:0]
    {
        WR_IDLE,
        WR_ADDR,
        WR_DATA
    } wr_state_t;

endpackage
